//--- include/objline_defines.svh
/* Object line renderer constants
   Table depth, sprite ROM and palette widths, screen width */
`ifndef OBJLINE_DEFINES_SVH
`define OBJLINE_DEFINES_SVH

// Sprite table, four bytes per entry
`define OBJ_MAX     32
`define OBJ_TBL_AW  7      // 128 bytes

// Visible line
`define SCR_W       256

// Parking spot for pixels that must not land on screen
`define OBJ_XOUT    9'h1F0

// Sprite ROM word address {code, row, quarter}
`define ROM_AW      16

// Object palette, {bank, colour index}
`define PAL_AW      6

`endif

//--- rtl/obj_types_pkg.sv
/* Object renderer types
   Sprite attributes, pixels, line buffer writes and drawer states */
package obj_types_pkg;

    typedef logic [9:0] obj_id_t;   // Sprite code
    typedef logic [1:0] obj_pal_t;  // Palette bank
    typedef logic [3:0] obj_col_t;  // Colour index, 15 = transparent
    typedef logic [8:0] obj_x_t;    // Bit 8 set = off-screen
    typedef logic [7:0] vline_t;    // Line number

    // Decoded table entry
    typedef struct packed {
        obj_id_t  id;
        obj_pal_t pal;
        logic     vflip;
        logic     hflip;
        obj_x_t   x;
    } obj_attr_t;

    // Display pixel
    typedef struct packed {
        logic       valid;
        logic [7:0] col;    // Palette output
    } obj_pxl_t;

    // Line buffer write
    typedef struct packed {
        logic     we;
        obj_x_t   x;
        obj_pxl_t pxl;
    } obj_wr_t;

    typedef enum logic [2:0] {
        IDLE,   // Waiting for line_start
        LOAD,   // Take an entry from the scanner
        TEST,   // Line zone check
        FETCH,  // ROM read in flight
        SHIFT,  // Four pixels out of the word
        NEXT    // Sprite done
    } draw_state_t;

endpackage

//--- rtl/obj_bus_pkg.sv
/* Sprite ROM bus types
   Wishbone classic read request and response */
`include "objline_defines.svh"

package obj_bus_pkg;

    // Master side, read only so no we or sel
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic [`ROM_AW-1:0] adr;
    } wb_req_t;

    // Slave side
    typedef struct packed {
        logic        ack;
        logic [15:0] dat;  // Four planes of four pixels
    } wb_rsp_t;

endpackage

//--- rtl/obj_scan.sv
`timescale 1ns/1ns
/* Sprite table scanner
   Holds the per-line table and hands one entry at a time to the drawer */
`include "objline_defines.svh"

module obj_scan (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tbl_we,
    input  logic [`OBJ_TBL_AW-1:0] tbl_addr,
    input  logic [7:0]             tbl_din,
    input  logic                   line_start,
    input  logic                   ent_take,
    output logic                   ent_valid,
    output logic [31:0]            ent_bytes,
    output logic                   scan_end
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,   // Gather four bytes
        S_OFFER,  // Entry waits for the drawer
        S_END
    } scan_state_t;

    scan_state_t state;
    logic [7:0] tbl_mem [0:2**`OBJ_TBL_AW-1];
    logic [`OBJ_TBL_AW-3:0] ent_idx;  // Entry number
    logic [1:0] bsel;                 // Byte in entry
    logic [7:0] rd_byte;

    // Host port
    always_ff @(posedge clk) begin
        if (tbl_we)
            tbl_mem[tbl_addr] <= tbl_din;
    end

    assign rd_byte = tbl_mem[{ent_idx, bsel}];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            ent_idx <= '0;
            bsel    <= 2'd0;
        end else begin
            case (state)
                S_IDLE, S_END: begin
                    if (line_start) begin  // Restart from entry 0
                        state   <= S_READ;
                        ent_idx <= '0;
                        bsel    <= 2'd0;
                    end
                end
                S_READ: begin
                    bsel <= bsel + 2'd1;
                    if (bsel == 2'd3)
                        state <= S_OFFER;
                end
                S_OFFER: begin
                    if (ent_take) begin
                        if (ent_idx == `OBJ_MAX-1) begin
                            state <= S_END;  // Table exhausted
                        end else begin
                            ent_idx <= ent_idx + 1'b1;
                            state   <= S_READ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Holding register, byte 0 at the bottom
    always_ff @(posedge clk) begin
        if (state == S_READ)
            ent_bytes[{bsel, 3'b000} +: 8] <= rd_byte;
    end

    assign ent_valid = (state == S_OFFER);
    assign scan_end  = (state == S_END);

endmodule

//--- rtl/obj_draw.sv
`timescale 1ns/1ns
/* Object drawer
   Zone test, sprite ROM fetch over Wishbone and pixel unpacking toward the line buffer */
`include "objline_defines.svh"

module obj_draw (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   line_start,
    input  obj_types_pkg::vline_t  vline,
    input  logic                   ent_valid,
    input  logic [31:0]            ent_bytes,
    input  logic                   scan_end,
    output logic                   ent_take,
    output obj_bus_pkg::wb_req_t   rom_req,
    input  obj_bus_pkg::wb_rsp_t   rom_rsp,
    output logic [`PAL_AW-1:0]     pal_addr,
    input  logic [7:0]             pal_q,
    output obj_types_pkg::obj_wr_t lb_wr,
    output logic                   busy,
    output logic                   line_done
);

    obj_types_pkg::draw_state_t state;
    obj_types_pkg::obj_attr_t   ent_attr;
    obj_types_pkg::obj_attr_t   attr;      // Sprite being drawn
    obj_types_pkg::vline_t      vnext;     // Line being prepared
    obj_types_pkg::vline_t      obj_y;
    obj_types_pkg::vline_t      vdiff;
    obj_types_pkg::obj_col_t    cur_col;
    obj_types_pkg::obj_x_t      dly_x;
    logic [3:0] row;
    logic [1:0] quarter;                   // Pixel group in the row
    logic [1:0] pix;                       // Pixel in the group
    logic [3:0] pl_z, pl_y, pl_x, pl_w;    // Plane shifters
    logic [9:0] px_cnt;                    // Wide so X cannot wrap on screen
    logic       cur_skip;
    logic       dly_v, dly_skip;           // Aligned with pal_q

    // GnG layout: code low, attribute, Y, X low
    assign ent_attr.id    = {ent_bytes[15:14], ent_bytes[7:0]};
    assign ent_attr.pal   = ent_bytes[13:12];
    assign ent_attr.vflip = ent_bytes[11];
    assign ent_attr.hflip = ent_bytes[10];
    assign ent_attr.x     = {ent_bytes[8], ent_bytes[31:24]};

    // Distance into the sprite, modulo 256
    assign vdiff = vnext - obj_y;

    // Next pixel from the plane edges
    assign cur_col = attr.hflip ? {pl_w[0], pl_x[0], pl_y[0], pl_z[0]}
                                : {pl_w[3], pl_x[3], pl_y[3], pl_z[3]};
    assign cur_skip = (cur_col == 4'hF) || (px_cnt >= `SCR_W);

    assign pal_addr = {attr.pal, cur_col};

    // Wishbone classic, held until ack
    assign rom_req.cyc = (state == obj_types_pkg::FETCH);
    assign rom_req.stb = (state == obj_types_pkg::FETCH);
    assign rom_req.adr = {attr.id, row ^ {4{~attr.vflip}}, quarter ^ {2{attr.hflip}}};

    // Palette data lands one cycle after the address
    assign lb_wr.we        = dly_v && !dly_skip;
    assign lb_wr.x         = dly_skip ? `OBJ_XOUT : dly_x;
    assign lb_wr.pxl.valid = dly_v && !dly_skip;
    assign lb_wr.pxl.col   = pal_q;

    assign ent_take  = (state == obj_types_pkg::LOAD) && ent_valid;
    assign line_done = (state == obj_types_pkg::LOAD) && !ent_valid && scan_end;
    assign busy      = (state != obj_types_pkg::IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= obj_types_pkg::IDLE;
            dly_v <= 1'b0;
        end else begin
            dly_v <= (state == obj_types_pkg::SHIFT);
            case (state)
                obj_types_pkg::IDLE: begin
                    if (line_start)
                        state <= obj_types_pkg::LOAD;
                end
                obj_types_pkg::LOAD: begin
                    if (ent_valid)
                        state <= obj_types_pkg::TEST;
                    else if (scan_end)
                        state <= obj_types_pkg::IDLE;  // Line complete
                end
                obj_types_pkg::TEST: begin
                    // Out of zone goes on with no ROM access
                    if (vdiff[7:4] == 4'd0)
                        state <= obj_types_pkg::FETCH;
                    else
                        state <= obj_types_pkg::NEXT;
                end
                obj_types_pkg::FETCH: begin
                    if (rom_rsp.ack)
                        state <= obj_types_pkg::SHIFT;
                end
                obj_types_pkg::SHIFT: begin
                    if (pix == 2'd3) begin
                        if (quarter == 2'd3)
                            state <= obj_types_pkg::NEXT;
                        else
                            state <= obj_types_pkg::FETCH;
                    end
                end
                obj_types_pkg::NEXT: state <= obj_types_pkg::LOAD;
                default: state <= obj_types_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            obj_types_pkg::IDLE: vnext <= vline + 8'd1;  // Sampled at line_start
            obj_types_pkg::LOAD: begin
                attr  <= ent_attr;
                obj_y <= ent_bytes[23:16];
            end
            obj_types_pkg::TEST: begin
                row     <= vdiff[3:0];
                quarter <= 2'd0;
                px_cnt  <= {1'b0, attr.x};
            end
            obj_types_pkg::FETCH: begin
                pix <= 2'd0;
                if (rom_rsp.ack)
                    {pl_z, pl_y, pl_x, pl_w} <= rom_rsp.dat;
            end
            obj_types_pkg::SHIFT: begin
                if (attr.hflip) begin
                    pl_z <= pl_z >> 1;
                    pl_y <= pl_y >> 1;
                    pl_x <= pl_x >> 1;
                    pl_w <= pl_w >> 1;
                end else begin
                    pl_z <= pl_z << 1;
                    pl_y <= pl_y << 1;
                    pl_x <= pl_x << 1;
                    pl_w <= pl_w << 1;
                end
                pix    <= pix + 2'd1;
                px_cnt <= px_cnt + 10'd1;  // Drawn from X upward
                if (pix == 2'd3)
                    quarter <= quarter + 2'd1;
            end
            default: ;
        endcase
        dly_x    <= px_cnt[8:0];
        dly_skip <= cur_skip;
    end

endmodule

//--- rtl/obj_pal_prom.sv
`timescale 1ns/1ns
/* Object palette
   Host-loaded 64x8 colour table, registered read for the drawer */
`include "objline_defines.svh"

module obj_pal_prom (
    input  logic               clk,
    input  logic               we,
    input  logic [`PAL_AW-1:0] waddr,
    input  logic [7:0]         din,
    input  logic [`PAL_AW-1:0] raddr,
    output logic [7:0]         q
);

    logic [7:0] mem [0:2**`PAL_AW-1];

    // Host write
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= din;
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        q <= mem[raddr];
    end

endmodule

//--- rtl/obj_linebuf.sv
`timescale 1ns/1ns
/* Double line buffer
   Drawer fills one half while the display reads and erases the other */
`include "objline_defines.svh"

module obj_linebuf (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   line_start,
    input  obj_types_pkg::obj_wr_t wr,
    input  logic                   rd_en,
    input  logic [7:0]             rd_x,
    output obj_types_pkg::obj_pxl_t pxl
);

    logic                     sel;       // Draw half, display reads ~sel
    logic [7:0]               col_mem [0:2*`SCR_W-1];
    logic [1:0][`SCR_W-1:0]   vld;       // Occupancy per half
    logic                     wr_ok;

    // Off-screen X never lands
    assign wr_ok = wr.we && !wr.x[8];

    // Colour store
    always_ff @(posedge clk) begin
        if (wr_ok)
            col_mem[{sel, wr.x[7:0]}] <= wr.pxl.col;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
            vld <= '0;  // Both halves empty
            pxl <= '0;
        end else begin
            if (line_start)
                sel <= ~sel;  // Swap halves
            if (wr_ok)
                vld[sel][wr.x[7:0]] <= wr.pxl.valid;
            pxl.valid <= rd_en && vld[~sel][rd_x];
            if (rd_en) begin
                pxl.col          <= col_mem[{~sel, rd_x}];
                vld[~sel][rd_x]  <= 1'b0;  // Read and erase
            end
        end
    end

endmodule

//--- rtl/obj_line_top.sv
`timescale 1ns/1ns
/* Sprite line renderer top
   Table scanner, object drawer, palette and double line buffer */
`include "objline_defines.svh"

module obj_line_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tbl_we,
    input  logic [`OBJ_TBL_AW-1:0]  tbl_addr,
    input  logic [7:0]              tbl_din,
    input  logic                    pal_we,
    input  logic [`PAL_AW-1:0]      pal_addr,
    input  logic [7:0]              pal_din,
    input  logic                    line_start,
    input  obj_types_pkg::vline_t   vline,
    output obj_bus_pkg::wb_req_t    rom_req,
    input  obj_bus_pkg::wb_rsp_t    rom_rsp,
    input  logic                    rd_en,
    input  logic [7:0]              rd_x,
    output obj_types_pkg::obj_pxl_t obj_pxl,
    output logic                    busy,
    output logic                    line_done
);

    logic                   ent_valid, ent_take, scan_end;
    logic [31:0]            ent_bytes;
    logic [`PAL_AW-1:0]     drw_pal_addr;  // Drawer side of the palette
    logic [7:0]             pal_q;
    obj_types_pkg::obj_wr_t lb_wr;

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .tbl_we     (tbl_we),
        .tbl_addr   (tbl_addr),
        .tbl_din    (tbl_din),
        .line_start (line_start),
        .ent_take   (ent_take),
        .ent_valid  (ent_valid),
        .ent_bytes  (ent_bytes),
        .scan_end   (scan_end)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vline      (vline),
        .ent_valid  (ent_valid),
        .ent_bytes  (ent_bytes),
        .scan_end   (scan_end),
        .ent_take   (ent_take),
        .rom_req    (rom_req),
        .rom_rsp    (rom_rsp),
        .pal_addr   (drw_pal_addr),
        .pal_q      (pal_q),
        .lb_wr      (lb_wr),
        .busy       (busy),
        .line_done  (line_done)
    );

    obj_pal_prom u_pal (
        .clk   (clk),
        .we    (pal_we),
        .waddr (pal_addr),
        .din   (pal_din),
        .raddr (drw_pal_addr),
        .q     (pal_q)
    );

    obj_linebuf u_linebuf (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .wr         (lb_wr),
        .rd_en      (rd_en),
        .rd_x       (rd_x),
        .pxl        (obj_pxl)
    );

endmodule

//--- test/tb_obj_rom_model.sv
`timescale 1ns/1ns
/* Sprite ROM model
   Wishbone classic read slave with random ack delay and a read counter */
`include "objline_defines.svh"

module tb_obj_rom_model (
    input  logic                 clk,
    input  logic                 rst,
    input  obj_bus_pkg::wb_req_t req,
    output obj_bus_pkg::wb_rsp_t rsp,
    output int                   reads
);

    integer     seed = 32'hb720_b340;
    logic       pend;      // Request seen, ack not yet given
    logic [1:0] wait_cnt;  // Extra wait states left

    // ROM contents, a fixed mix of the address with some transparent pixels
    function automatic logic [15:0] word_at(input logic [15:0] a);
        logic [15:0] h;
        logic [3:0]  m;
        h = (a * 16'h9E37) ^ {5'd0, a[15:5]};
        m = (a[3:0] ^ a[9:6]) & 4'b1010;  // Pixels forced to index 15
        return h | {m, m, m, m};
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp      <= '0;
            pend     <= 1'b0;
            wait_cnt <= 2'd0;
            reads    <= 0;
        end else begin
            rsp.ack <= 1'b0;  // Single cycle ack
            if (rsp.ack) begin
                if (req.cyc && req.stb)
                    reads <= reads + 1;  // Acked strobe
            end else if (req.cyc && req.stb) begin
                if (!pend) begin
                    pend     <= 1'b1;
                    wait_cnt <= 2'($random(seed));  // 0 to 3 wait states
                end else if (wait_cnt == 2'd0) begin
                    pend    <= 1'b0;
                    rsp.ack <= 1'b1;
                    rsp.dat <= word_at(req.adr);
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

//--- test/tb_obj_line.sv
`timescale 1ns/1ns
/* Sprite line renderer testbench
   Table of line cases checked against a software model of the drawn line */
`include "objline_defines.svh"

module tb_obj_line;

    typedef struct packed {
        logic [7:0]  vl;     // Current line as drawing targets vl+1
        logic [1:0]  n;      // Sprites used in entries 0 and 1
        logic [31:0] s0;
        logic [31:0] s1;
        logic [7:0]  pkey;   // Palette fill key
        logic [7:0]  reads;  // Expected ROM reads
    } case_t;

    localparam int NCASE = 7;
    localparam int TMO   = 4000;  // Cycles per wait

    logic                      clk;
    logic                      rst;
    logic                      tbl_we;
    logic [`OBJ_TBL_AW-1:0]    tbl_addr;
    logic [7:0]                tbl_din;
    logic                      pal_we;
    logic [`PAL_AW-1:0]        pal_addr;
    logic [7:0]                pal_din;
    logic                      line_start;
    obj_types_pkg::vline_t     vline;
    obj_bus_pkg::wb_req_t      rom_req;
    obj_bus_pkg::wb_rsp_t      rom_rsp;
    logic                      rd_en;
    logic [7:0]                rd_x;
    obj_types_pkg::obj_pxl_t   obj_pxl;
    logic                      busy;
    logic                      line_done;
    int                        rom_reads;
    int                        errors, timeouts, checks;
    case_t                     cases [0:NCASE-1];
    logic [7:0]                pal_ref [0:63];    // Host copy of the palette
    obj_types_pkg::obj_pxl_t   exp_line [0:255];  // Model output

    obj_line_top dut (.*);

    tb_obj_rom_model rom (.clk(clk), .rst(rst), .req(rom_req), .rsp(rom_rsp), .reads(rom_reads));

    always #10 clk = ~clk;

    // Table entry bytes with the code low byte at the bottom
    function automatic logic [31:0] spr(input logic [9:0] code, input logic [1:0] pal,
                                        input logic vf, input logic hf,
                                        input logic [8:0] x, input logic [7:0] y);
        return {x[7:0], y, code[9:8], pal, vf, hf, 1'b0, x[8], code[7:0]};
    endfunction

    // Same contents as the ROM model
    function automatic logic [15:0] rom_data(input logic [15:0] a);
        logic [15:0] h;
        logic [3:0]  m;
        h = (a * 16'h9E37) ^ {5'd0, a[15:5]};
        m = (a[3:0] ^ a[9:6]) & 4'b1010;
        return h | {m, m, m, m};
    endfunction

    function automatic logic [7:0] pal_val(input logic [5:0] a, input logic [7:0] key);
        return ({2'b00, a} * 8'h1D) ^ key;
    endfunction

    // Expected line from the zone, fetch, unpack and overlap rules
    task automatic build_expected(input case_t c, output int nreads);
        logic [31:0] ent;
        logic [7:0]  d;
        logic [3:0]  r, col;
        logic [1:0]  qq;
        logic [15:0] w;
        int          px, b;
        for (int i = 0; i < 256; i++)
            exp_line[i] = '0;
        nreads = 0;
        for (int s = 0; s < 2; s++) begin
            ent = (s == 0) ? c.s0 : c.s1;
            d   = c.vl + 8'd1 - ent[23:16];  // Modulo 256
            if (s < c.n && d < 8'd16) begin
                nreads += 4;
                r = ent[11] ? d[3:0] : ~d[3:0];  // vflip clear inverts the row
                for (int q = 0; q < 4; q++) begin
                    qq = ent[10] ? ~q[1:0] : q[1:0];
                    w  = rom_data({ent[15:14], ent[7:0], r, qq});
                    for (int j = 0; j < 4; j++) begin
                        b   = ent[10] ? j : 3 - j;  // hflip takes the low bit first
                        col = {w[b], w[4+b], w[8+b], w[12+b]};
                        px  = {ent[8], ent[31:24]} + q * 4 + j;
                        if (col != 4'hF && px < `SCR_W)
                            exp_line[px] = '{valid: 1'b1, col: pal_ref[{ent[13:12], col}]};
                    end
                end
            end
        end
    endtask

    task automatic chk_pxl(input string name, input obj_types_pkg::obj_pxl_t got,
                           input obj_types_pkg::obj_pxl_t exp);
        checks++;
        if (got.valid !== exp.valid || (exp.valid && got.col !== exp.col)) begin
            errors++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic chk_cnt(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic wait_done(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TMO && !ok; n++) begin
            @(negedge clk);
            ok = line_done;
        end
    endtask

    task automatic wait_idle(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TMO && !ok; n++) begin
            @(negedge clk);
            ok = !busy;
        end
    endtask

    // Table with unused entries parked far off the line and then the palette
    task automatic load_case(input case_t c);
        logic [31:0] ent;
        for (int e = 0; e < `OBJ_MAX; e++) begin
            ent = (e == 0 && c.n > 0) ? c.s0 :
                  (e == 1 && c.n > 1) ? c.s1 : {8'd0, c.vl + 8'd129, 16'h0000};
            for (int k = 0; k < 4; k++) begin
                @(negedge clk);
                tbl_we   = 1'b1;
                tbl_addr = 7'(e * 4 + k);
                tbl_din  = ent[8*k +: 8];
            end
        end
        for (int a = 0; a < 64; a++) begin
            @(negedge clk);
            tbl_we     = 1'b0;
            pal_we     = 1'b1;
            pal_addr   = 6'(a);
            pal_din    = pal_val(6'(a), c.pkey);
            pal_ref[a] = pal_din;
        end
        @(negedge clk);
        pal_we = 1'b0;
        vline  = c.vl;
    endtask

    task automatic pulse_line_start();
        @(negedge clk);
        line_start = 1'b1;
        @(negedge clk);
        line_start = 1'b0;
    endtask

    // Full display read where the second pass sees an erased line
    task automatic read_line(input bit erased);
        obj_types_pkg::obj_pxl_t none;
        none = '0;
        for (int x = 0; x < 256; x++) begin
            @(negedge clk);
            rd_en = 1'b1;
            rd_x  = 8'(x);
            @(negedge clk);
            rd_en = 1'b0;
            chk_pxl($sformatf("obj_pxl[%0d]", x), obj_pxl, erased ? none : exp_line[x]);
        end
    endtask

    initial begin
        int  model_reads, base;
        bit  ok;
        clk        = 1'b0;
        rst        = 1'b1;
        tbl_we     = 1'b0;
        tbl_addr   = '0;
        tbl_din    = 8'd0;
        pal_we     = 1'b0;
        pal_addr   = '0;
        pal_din    = 8'd0;
        line_start = 1'b0;
        vline      = 8'd0;
        rd_en      = 1'b0;
        rd_x       = 8'd0;
        errors     = 0;
        timeouts   = 0;
        checks     = 0;
        // Plain sprite, hflip, vflip, both flips across the Y wrap
        cases[0] = '{8'd40, 2'd1, spr(10'h05A, 2'd1, 1'b0, 1'b0, 9'd20, 8'd35), 32'd0,
                     8'h3C, 8'd4};
        cases[1] = '{8'd40, 2'd1, spr(10'h123, 2'd2, 1'b0, 1'b1, 9'd100, 8'd30), 32'd0,
                     8'h51, 8'd4};
        cases[2] = '{8'd99, 2'd1, spr(10'h2C7, 2'd3, 1'b1, 1'b0, 9'd60, 8'd90), 32'd0,
                     8'hA6, 8'd4};
        cases[3] = '{8'd3, 2'd1, spr(10'h0F1, 2'd0, 1'b1, 1'b1, 9'd200, 8'd250), 32'd0,
                     8'h0F, 8'd4};
        // One line above and one line below the zone
        cases[4] = '{8'd40, 2'd2, spr(10'h0AA, 2'd1, 1'b0, 1'b0, 9'd30, 8'd42),
                     spr(10'h155, 2'd2, 1'b0, 1'b0, 9'd80, 8'd25), 8'h77, 8'd0};
        // Overlap with entry 1 on top
        cases[5] = '{8'd120, 2'd2, spr(10'h011, 2'd1, 1'b0, 1'b0, 9'd50, 8'd115),
                     spr(10'h3F0, 2'd2, 1'b0, 1'b1, 9'd58, 8'd110), 8'hC3, 8'd8};
        // Right edge clip and X bit 8 on zone rows 15 and 0
        cases[6] = '{8'd200, 2'd2, spr(10'h2A5, 2'd3, 1'b0, 1'b0, 9'd248, 8'd186),
                     spr(10'h1B2, 2'd0, 1'b0, 1'b0, 9'h105, 8'd201), 8'h9E, 8'd8};
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int ci = 0; ci < NCASE && timeouts == 0; ci++) begin
            load_case(cases[ci]);
            build_expected(cases[ci], model_reads);
            base = rom_reads;
            pulse_line_start();
            wait_done(ok);
            if (!ok) begin
                timeouts++;
                $display("case %0d: line_done did not arrive", ci);
            end else begin
                chk_cnt("rom_reads", rom_reads - base, int'(cases[ci].reads));
                chk_cnt("model_reads", model_reads, int'(cases[ci].reads));
                wait_idle(ok);
                if (!ok) begin
                    timeouts++;
                    $display("case %0d: drawer stayed busy after line_done", ci);
                end else begin
                    pulse_line_start();  // Swap halves while the drawer redraws the other one
                    read_line(1'b0);
                    read_line(1'b1);
                    wait_idle(ok);
                    if (!ok) begin
                        timeouts++;
                        $display("case %0d: drawer stayed busy after the swap", ci);
                    end
                end
            end
        end
        $display("checks=%0d mismatches=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
rtl/obj_types_pkg.sv
rtl/obj_bus_pkg.sv
rtl/obj_scan.sv
rtl/obj_draw.sv
rtl/obj_pal_prom.sv
rtl/obj_linebuf.sv
rtl/obj_line_top.sv
test/tb_obj_rom_model.sv
test/tb_obj_line.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sprite line renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_obj_line -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_obj_line > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
